/* hw/colmix_pkg.sv */
// shared types and widths for the colour mixer
package colmix_pkg;

    // layer pixel width, one palette-index byte per layer
    localparam int PXL_W   = 8;

    // palette address = layer (2 bits) + pixel byte
    localparam int PAL_AW  = 10;

    // priority table address width
    localparam int PRIO_AW = 8;

    // stored colour channel width, doubled on output
    localparam int CH_W    = 4;

    // source layer picked by the priority table
    // value doubles as the palette bank, so keep the order fixed
    typedef enum logic [1:0] {
        LAYER_OBJ = 2'd0,   // sprites
        LAYER_BA0 = 2'd1,   // background 0
        LAYER_BA1 = 2'd2,   // background 1
        LAYER_BA2 = 2'd3    // background 2, lowest plane
    } layer_e;

endpackage

/* hw/colmix_prio.sv */
`timescale 1ns/1ns

// priority stage
// strobe k   : table address and pixels registered
// strobe k+1 : table result registered, pal_addr follows combinationally
module colmix_prio (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  logic [2:0]                    prisel,   // from game cpu
    input  logic [3:0]                    gfx_en,   // ba0, ba1, ba2, obj
    input  logic [7:0]                    obj_pxl,
    input  logic [7:0]                    ba0_pxl,
    input  logic [7:0]                    ba1_pxl,
    input  logic [7:0]                    ba2_pxl,
    input  logic [7:0]                    prog_addr,
    input  logic [1:0]                    prog_data,
    input  logic                          prog_we,
    output logic [colmix_pkg::PAL_AW-1:0] pal_addr
);

    // priority table, loaded like a prom, not reset
    logic [1:0] prio_tbl [0:2**colmix_pkg::PRIO_AW-1];

    logic obj_trn;  // per layer transparency
    logic ba0_trn;
    logic ba1_trn;  // low three bits only, as the board decodes it
    logic ba2_trn;

    logic [colmix_pkg::PRIO_AW-1:0] tbl_addr;
    logic [colmix_pkg::PRIO_AW-1:0] tbl_addr_q;

    // pixels packed in layer_e order so the winner indexes them directly
    logic [3:0][colmix_pkg::PXL_W-1:0] pxl_in;
    logic [3:0][colmix_pkg::PXL_W-1:0] pxl_q;   // aligned with tbl_addr_q
    logic [3:0][colmix_pkg::PXL_W-1:0] pxl_qq;  // aligned with win_q

    colmix_pkg::layer_e win_q;

    // a disabled layer always looks transparent
    assign obj_trn = ~|obj_pxl[3:0] | ~gfx_en[3];
    assign ba0_trn = ~|ba0_pxl[3:0] | ~gfx_en[0];
    assign ba1_trn = ~|ba1_pxl[2:0] | ~gfx_en[1];
    assign ba2_trn = ~|ba2_pxl[3:0] | ~gfx_en[2];

    // only the low end of the decode fits the 256 entry table
    assign tbl_addr = {
        prisel[0],      // 7, upper select bits fall outside the table
        ba0_trn,        // 6
        obj_pxl[7],     // 5 obj priority bit
        obj_trn,        // 4
        ba1_pxl[7],     // 3
        ba1_pxl[3],     // 2
        ba1_trn,        // 1
        ba2_trn         // 0
    };

    assign pxl_in = {ba2_pxl, ba1_pxl, ba0_pxl, obj_pxl};

    // table load, independent of the pixel strobe
    always_ff @(posedge clk) begin
        if (prog_we) begin
            prio_tbl[prog_addr] <= prog_data;
        end
    end

    // two pipeline steps, both on the pixel strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tbl_addr_q <= '0;
            pxl_q      <= '0;
            pxl_qq     <= '0;
            win_q      <= colmix_pkg::LAYER_OBJ;
        end else if (pxl_cen) begin
            tbl_addr_q <= tbl_addr;                     // step 1
            pxl_q      <= pxl_in;
            win_q      <= colmix_pkg::layer_e'(prio_tbl[tbl_addr_q]); // step 2
            pxl_qq     <= pxl_q;
        end
    end

    // bank from the winner, index is the winner's full byte
    assign pal_addr = {win_q, pxl_qq[win_q]};

endmodule

/* hw/colmix_palette.sv */
`timescale 1ns/1ns

// palette ram shared between the cpu and the video pipeline
// word layout: 3:0 red, 7:4 green, 11:8 blue, 15:12 unused
module colmix_palette #(
    parameter int PAL_AW = colmix_pkg::PAL_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  logic [PAL_AW-1:0] pal_addr,  // from the priority stage
    input  logic              cpu_cs,
    input  logic [PAL_AW-1:0] cpu_addr,
    input  logic [15:0]       cpu_dout,
    input  logic [1:0]        cpu_we,    // byte lanes, 1 = write
    output logic [15:0]       cpu_din,
    output logic [11:0]       pal_bgr
);

    logic [15:0] mem [0:2**PAL_AW-1];  // contents survive reset

    logic [1:0] lane_we;

    // lanes only count while selected
    assign lane_we = cpu_we & {2{cpu_cs}};

    // cpu port
    // read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (lane_we[0]) begin
            mem[cpu_addr][7:0] <= cpu_dout[7:0];    // green, red
        end
        if (lane_we[1]) begin
            mem[cpu_addr][15:8] <= cpu_dout[15:8];  // blue + spare nibble
        end
        cpu_din <= mem[cpu_addr];
    end

    // video port, advances on the pixel strobe only
    // cpu may rewrite entries mid frame, the next strobe picks them up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pal_bgr <= '0;
        end else if (pxl_cen) begin
            pal_bgr <= mem[pal_addr][11:0];  // top nibble never displayed
        end
    end

endmodule

/* hw/colmix_out.sv */
`timescale 1ns/1ns

// output stage
// blanking goes through three strobes so it meets the colour of the same pixel
module colmix_out (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  logic [11:0] pal_bgr,   // {blue, green, red}
    input  logic        hblank_n,
    input  logic        vblank_n,
    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue,
    output logic        hblank_dly_n,
    output logic        vblank_dly_n
);

    localparam int CW = colmix_pkg::CH_W;

    logic [2:0] hb_sr;  // bit 2 lines up with pal_bgr
    logic [2:0] vb_sr;

    logic [CW-1:0] r4;
    logic [CW-1:0] g4;
    logic [CW-1:0] b4;

    logic visible;

    assign r4 = pal_bgr[CW-1:0];
    assign g4 = pal_bgr[2*CW-1:CW];
    assign b4 = pal_bgr[3*CW-1:2*CW];

    // both flags high means active video
    assign visible = hb_sr[2] & vb_sr[2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hb_sr        <= '0;
            vb_sr        <= '0;
            red          <= '0;
            green        <= '0;
            blue         <= '0;
            hblank_dly_n <= 1'b0;
            vblank_dly_n <= 1'b0;
        end else if (pxl_cen) begin
            hb_sr        <= {hb_sr[1:0], hblank_n};
            vb_sr        <= {vb_sr[1:0], vblank_n};
            hblank_dly_n <= hb_sr[2];
            vblank_dly_n <= vb_sr[2];
            // 4 to 8 bits by repeating the nibble, black in blanking
            red          <= visible ? {2{r4}} : '0;
            green        <= visible ? {2{g4}} : '0;
            blue         <= visible ? {2{b4}} : '0;
        end
    end

endmodule

/* hw/colmix_top.sv */
`timescale 1ns/1ns

// colour mixer, priority -> palette -> output
module colmix_top #(
    parameter int PAL_AW = colmix_pkg::PAL_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  logic [2:0]        prisel,
    input  logic [3:0]        gfx_en,
    input  logic [7:0]        obj_pxl,
    input  logic [7:0]        ba0_pxl,
    input  logic [7:0]        ba1_pxl,
    input  logic [7:0]        ba2_pxl,
    input  logic [7:0]        prog_addr,   // priority table load
    input  logic [1:0]        prog_data,
    input  logic              prog_we,
    input  logic              cpu_cs,      // palette cpu port
    input  logic [PAL_AW-1:0] cpu_addr,
    input  logic [15:0]       cpu_dout,
    input  logic [1:0]        cpu_we,
    output logic [15:0]       cpu_din,
    input  logic              hblank_n,
    input  logic              vblank_n,
    output logic [7:0]        red,
    output logic [7:0]        green,
    output logic [7:0]        blue,
    output logic              hblank_dly_n,
    output logic              vblank_dly_n
);

    logic [colmix_pkg::PAL_AW-1:0] prio_addr;  // full width from prio
    logic [11:0]                   pal_bgr;

    colmix_prio u_prio (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .prisel    (prisel),
        .gfx_en    (gfx_en),
        .obj_pxl   (obj_pxl),
        .ba0_pxl   (ba0_pxl),
        .ba1_pxl   (ba1_pxl),
        .ba2_pxl   (ba2_pxl),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_we   (prog_we),
        .pal_addr  (prio_addr)
    );

    // a smaller palette drops the top address bits
    colmix_palette #(
        .PAL_AW (PAL_AW)
    ) u_palette (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pal_addr (prio_addr[PAL_AW-1:0]),
        .cpu_cs   (cpu_cs),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_we   (cpu_we),
        .cpu_din  (cpu_din),
        .pal_bgr  (pal_bgr)
    );

    colmix_out u_out (
        .clk          (clk),
        .rst_n        (rst_n),
        .pxl_cen      (pxl_cen),
        .pal_bgr      (pal_bgr),
        .hblank_n     (hblank_n),
        .vblank_n     (vblank_n),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hblank_dly_n (hblank_dly_n),
        .vblank_dly_n (vblank_dly_n)
    );

endmodule

/* test/colmix_tb.sv */
`timescale 1ns/1ns

module colmix_tb;

    localparam int PAL_AW = colmix_pkg::PAL_AW;

    logic              clk;
    logic              rst_n;
    logic              pxl_cen;
    logic [2:0]        prisel;
    logic [3:0]        gfx_en;   // ba0, ba1, ba2, obj
    logic [7:0]        obj_pxl;
    logic [7:0]        ba0_pxl;
    logic [7:0]        ba1_pxl;
    logic [7:0]        ba2_pxl;
    logic [7:0]        prog_addr;
    logic [1:0]        prog_data;
    logic              prog_we;
    logic              cpu_cs;
    logic [PAL_AW-1:0] cpu_addr;
    logic [15:0]       cpu_dout;
    logic [1:0]        cpu_we;
    logic [15:0]       cpu_din;
    logic              hblank_n;
    logic              vblank_n;
    logic [7:0]        red;
    logic [7:0]        green;
    logic [7:0]        blue;
    logic              hblank_dly_n;
    logic              vblank_dly_n;

    integer seed = 15056;

    // images of what the testbench wrote into the DUT
    logic [1:0]  tbl_img [0:255];
    logic [15:0] pal_img [0:2**PAL_AW-1];

    // one entry per strobe, oldest at the front
    logic [PAL_AW-1:0] q_addr [$];
    logic [11:0]       q_bgr  [$];
    logic              q_hb   [$];
    logic              q_vb   [$];

    logic        chk_en;
    logic [23:0] exp_rgb;     // {red, green, blue}
    logic [1:0]  exp_blank;   // {hblank, vblank}
    logic [23:0] nxt_rgb;
    logic [1:0]  nxt_blank;
    logic        pend_out;
    logic [15:0] exp_din;
    logic [15:0] nxt_din;
    logic        pend_din;
    logic        din_chk;

    colmix_top #(
        .PAL_AW (PAL_AW)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .pxl_cen      (pxl_cen),
        .prisel       (prisel),
        .gfx_en       (gfx_en),
        .obj_pxl      (obj_pxl),
        .ba0_pxl      (ba0_pxl),
        .ba1_pxl      (ba1_pxl),
        .ba2_pxl      (ba2_pxl),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .prog_we      (prog_we),
        .cpu_cs       (cpu_cs),
        .cpu_addr     (cpu_addr),
        .cpu_dout     (cpu_dout),
        .cpu_we       (cpu_we),
        .cpu_din      (cpu_din),
        .hblank_n     (hblank_n),
        .vblank_n     (vblank_n),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hblank_dly_n (hblank_dly_n),
        .vblank_dly_n (vblank_dly_n)
    );

    always #5 clk = ~clk;  // 10 ns period

    task automatic fail_now(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "output check failed");
    endtask

    // outputs against the entry three strobes old
    a_colour: assert property (@(posedge clk) chk_en |-> ({red, green, blue} == exp_rgb))
        else fail_now($sformatf("rgb %h, expected %h",
                                $sampled({red, green, blue}), $sampled(exp_rgb)));

    a_blank: assert property (@(posedge clk)
                              chk_en |-> ({hblank_dly_n, vblank_dly_n} == exp_blank))
        else fail_now($sformatf("blank pair %b, expected %b",
                                $sampled({hblank_dly_n, vblank_dly_n}), $sampled(exp_blank)));

    // no strobe, no change
    a_stall: assert property (@(posedge clk)
                              (chk_en && $past(chk_en) && !$past(pxl_cen)) |->
                              $stable({red, green, blue, hblank_dly_n, vblank_dly_n}))
        else fail_now("outputs moved without a pixel strobe");

    a_cpu_read: assert property (@(posedge clk) din_chk |-> (cpu_din == exp_din))
        else fail_now($sformatf("cpu_din %h, expected %h",
                                $sampled(cpu_din), $sampled(exp_din)));

    // commit last cycle's expectations, then drop the one-shot strobes
    task automatic next_negedge();
        @(negedge clk);
        if (pend_out) begin
            exp_rgb   = nxt_rgb;
            exp_blank = nxt_blank;
            pend_out  = 1'b0;
        end
        din_chk  = pend_din;
        exp_din  = nxt_din;
        pend_din = 1'b0;
        pxl_cen  = 1'b0;
        cpu_cs   = 1'b0;
        cpu_we   = 2'b00;
        prog_we  = 1'b0;
    endtask

    // reference model, one call per strobe with the inputs already driven
    task automatic model_strobe();
        logic               obj_t;
        logic               ba0_t;
        logic               ba1_t;
        logic               ba2_t;
        logic [9:0]         rule;
        colmix_pkg::layer_e win;
        logic [7:0]         sel;
        logic [11:0]        bgr;
        logic               vis;
        int                 m;
        obj_t = (obj_pxl[3:0] == 4'h0) || !gfx_en[3];
        ba0_t = (ba0_pxl[3:0] == 4'h0) || !gfx_en[0];
        ba1_t = (ba1_pxl[2:0] == 3'h0) || !gfx_en[1];  // low three bits on ba1
        ba2_t = (ba2_pxl[3:0] == 4'h0) || !gfx_en[2];
        rule  = {prisel, ba0_t, obj_pxl[7], obj_t, ba1_pxl[7], ba1_pxl[3], ba1_t, ba2_t};
        win   = colmix_pkg::layer_e'(tbl_img[rule[7:0]]);  // 256 entries, low byte
        case (win)
            colmix_pkg::LAYER_OBJ: sel = obj_pxl;
            colmix_pkg::LAYER_BA0: sel = ba0_pxl;
            colmix_pkg::LAYER_BA1: sel = ba1_pxl;
            default:               sel = ba2_pxl;
        endcase
        q_addr.push_back({win, sel});
        q_bgr.push_back(12'h000);
        q_hb.push_back(hblank_n);
        q_vb.push_back(vblank_n);
        m = q_addr.size();
        q_bgr[m-3] = pal_img[q_addr[m-3]][11:0];  // palette read two strobes in
        bgr = q_bgr[0];
        vis = q_hb[0] && q_vb[0];
        nxt_rgb   = vis ? {{2{bgr[3:0]}}, {2{bgr[7:4]}}, {2{bgr[11:8]}}} : 24'h0;
        nxt_blank = {q_hb[0], q_vb[0]};
        pend_out  = 1'b1;
        void'(q_addr.pop_front());
        void'(q_bgr.pop_front());
        void'(q_hb.pop_front());
        void'(q_vb.pop_front());
    endtask

    task automatic strobe_cycle(input logic [7:0] obj, input logic [7:0] ba0,
                                input logic [7:0] ba1, input logic [7:0] ba2,
                                input logic [2:0] ps, input logic [3:0] gfx,
                                input logic hb, input logic vb);
        next_negedge();
        obj_pxl  = obj;
        ba0_pxl  = ba0;
        ba1_pxl  = ba1;
        ba2_pxl  = ba2;
        prisel   = ps;
        gfx_en   = gfx;
        hblank_n = hb;
        vblank_n = vb;
        pxl_cen  = 1'b1;
        model_strobe();
    endtask

    task automatic cpu_access(input logic [PAL_AW-1:0] addr, input logic [1:0] we,
                              input logic [15:0] data, input bit check);
        next_negedge();
        cpu_cs   = 1'b1;
        cpu_addr = addr;
        cpu_we   = we;
        cpu_dout = data;
        nxt_din  = pal_img[addr];  // old word even on a write
        pend_din = check;
        if (we[0]) pal_img[addr][7:0] = data[7:0];
        if (we[1]) pal_img[addr][15:8] = data[15:8];
    endtask

    task automatic rand_pixel(output logic [7:0] p);
        logic [31:0] r;
        r = $random(seed);
        p = r[7:0];
        if (r[9:8] == 2'b00) p[3:0] = 4'h0;    // plenty of transparent pixels
        if (r[11:10] == 2'b00) p[2:0] = 3'h0;
    endtask

    // random pixels, strobe every second cycle plus random gaps
    task automatic run_pixels(input int n, input bit rand_gfx, input logic [3:0] gfx,
                              input int max_gap);
        logic [7:0]  p0;
        logic [7:0]  p1;
        logic [7:0]  p2;
        logic [7:0]  p3;
        logic [31:0] r;
        int          gap;
        for (int i = 0; i < n; i++) begin
            rand_pixel(p0);
            rand_pixel(p1);
            rand_pixel(p2);
            rand_pixel(p3);
            r = $random(seed);
            strobe_cycle(p0, p1, p2, p3, r[2:0], rand_gfx ? r[6:3] : gfx,
                         r[9:7] != 3'b000, r[12:10] != 3'b000);
            gap = 1;
            if (r[14:13] == 2'b00) gap = 1 + ({$random(seed)} % max_gap);
            repeat (gap) next_negedge();
        end
    endtask

    initial begin
        logic [7:0]  b;
        logic [31:0] r;
        logic [1:0]  we;
        int          cnt;
        bit          done;
        clk       = 1'b0;
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        prisel    = 3'h0;
        gfx_en    = 4'hf;
        obj_pxl   = 8'h00;
        ba0_pxl   = 8'h00;
        ba1_pxl   = 8'h00;
        ba2_pxl   = 8'h00;
        prog_addr = 8'h00;
        prog_data = 2'b00;
        prog_we   = 1'b0;
        cpu_cs    = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = 16'h0000;
        cpu_we    = 2'b00;
        hblank_n  = 1'b0;
        vblank_n  = 1'b0;
        chk_en    = 1'b0;
        exp_rgb   = 24'h0;  // all outputs zero out of reset
        exp_blank = 2'b00;
        nxt_rgb   = 24'h0;
        nxt_blank = 2'b00;
        pend_out  = 1'b0;
        exp_din   = 16'h0;
        nxt_din   = 16'h0;
        pend_din  = 1'b0;
        din_chk   = 1'b0;
        // pipeline state after reset, blanked so colour does not matter
        repeat (3) begin
            q_addr.push_back('0);
            q_bgr.push_back(12'h000);
            q_hb.push_back(1'b0);
            q_vb.push_back(1'b0);
        end

        next_negedge();
        chk_en = 1'b1;
        repeat (8) next_negedge();
        rst_n = 1'b1;

        // random priority table
        for (int a = 0; a < 256; a++) begin
            next_negedge();
            r            = $random(seed);
            prog_we      = 1'b1;
            prog_addr    = a[7:0];
            prog_data    = r[1:0];
            tbl_img[a]   = prog_data;
        end
        // palette encodes its own address, spare nibble included
        for (int a = 0; a < 2**PAL_AW; a++) begin
            cpu_access(a[PAL_AW-1:0], 2'b11, {6'h2a, a[9:0]}, 1'b0);
        end
        next_negedge();

        run_pixels(400, 1'b1, 4'hf, 4);           // table picks, all layers on

        for (int g = 0; g < 16; g++) begin
            run_pixels(20, 1'b0, g[3:0], 3);      // each enable pattern
        end

        // cpu port, byte lanes then pixels on the rewritten entries
        repeat (6) begin
            r = $random(seed);
            b = r[7:0];
            for (int l = 0; l < 4; l++) begin
                r  = $random(seed);
                we = (r[1:0] == 2'b00) ? 2'b11 : r[1:0];
                cpu_access({l[1:0], b}, 2'b00, 16'h0000, 1'b1);
                cpu_access({l[1:0], b}, we, r[31:16], 1'b1);
                cpu_access({l[1:0], b}, 2'b00, 16'h0000, 1'b1);
            end
            next_negedge();
            repeat (8) begin
                r = $random(seed);
                strobe_cycle(b, b, b, b, r[2:0], r[6:3], 1'b1, 1'b1);
                next_negedge();
            end
        end

        run_pixels(100, 1'b1, 4'hf, 16);         // long stalls

        // drain with active video until the delayed flags come back
        cnt  = 0;
        done = 1'b0;
        while (!done) begin
            strobe_cycle(8'h00, 8'h00, 8'h00, 8'h00, 3'h0, 4'hf, 1'b1, 1'b1);
            next_negedge();
            cnt++;
            if (cnt >= 4 && hblank_dly_n && vblank_dly_n) begin
                done = 1'b1;
            end else if (cnt > 20) begin
                $display("timeout: delayed blanking never returned high after the drain");
                $display("*** TEST FAILED ***");
                $fatal(1, "drain timeout");
            end
        end
        repeat (3) next_negedge();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* colmix.f */
hw/colmix_pkg.sv
hw/colmix_prio.sv
hw/colmix_palette.sv
hw/colmix_out.sv
hw/colmix_top.sv
test/colmix_tb.sv

/* Makefile */
# colour mixer simulation with Verilator

TOP = colmix_tb

.PHONY: all sim lint clean

all: sim

sim:
	verilator --binary --timing --assert -f colmix.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

lint:
	verilator --lint-only -Wall --timing -f colmix.f --top-module $(TOP)

clean:
	rm -rf obj_dir
